/* adc_self_trigger.sv */
`timescale 1ns/10ps

module adc_self_trigger #(
  parameter int POST_LEN  = 6,
  parameter int ACQUI_LEN = 24,
  parameter int AVG_LOG2  = 3
) (
  input  logic                              CLK,
  input  logic                              RESETN,
  // adc stream
  input  logic [adc_trig_pkg::WORD_W-1:0]   s_data,
  input  logic                              s_valid,
  input  logic [adc_trig_pkg::TS_W-1:0]     current_time,
  input  logic                              downstream_ready,
  // apb
  input  logic [adc_trig_pkg::APB_AW-1:0]   paddr,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [adc_trig_pkg::APB_DW-1:0]   pwdata,
  output logic [adc_trig_pkg::APB_DW-1:0]   prdata,
  output logic                              pready,
  output logic                              pslverr,
  // packet stream
  output logic [adc_trig_pkg::WORD_W-1:0]   m_data,
  output logic                              m_valid,
  output logic                              m_header,
  output logic                              m_last
);

  logic hit_word;

  trig_cfg_if   cfg ();
  trig_event_if evt ();

  trig_csr i_csr (
    .CLK     (CLK),
    .RESETN  (RESETN),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .cfg     (cfg.csr),
    .evt     (evt.frame)
  );

  hit_discriminator #(
    .POST_LEN  (POST_LEN),
    .ACQUI_LEN (ACQUI_LEN)
  ) i_disc (
    .CLK              (CLK),
    .RESETN           (RESETN),
    .s_data           (s_data),
    .s_valid          (s_valid),
    .current_time     (current_time),
    .downstream_ready (downstream_ready),
    .cfg              (cfg.disc),
    .evt              (evt.disc),
    .hit_word         (hit_word)
  );

  baseline_tracker #(
    .AVG_LOG2 (AVG_LOG2)
  ) i_track (
    .CLK      (CLK),
    .RESETN   (RESETN),
    .s_data   (s_data),
    .s_valid  (s_valid),
    .hit_word (hit_word),
    .cfg      (cfg.track)
  );

  event_framer #(
    .ACQUI_LEN (ACQUI_LEN)
  ) i_framer (
    .CLK      (CLK),
    .RESETN   (RESETN),
    .evt      (evt.frame),
    .m_data   (m_data),
    .m_valid  (m_valid),
    .m_header (m_header),
    .m_last   (m_last)
  );

endmodule

/* adc_trig_pkg.sv */
package adc_trig_pkg;

  // stream geometry
  localparam int LANES  = 8;
  localparam int LANE_W = 16;
  localparam int ADC_W  = 12;
  localparam int WORD_W = LANES * LANE_W;
  localparam int TS_W   = 48;

  // header field widths
  localparam int EVT_W  = 16;
  localparam int WCNT_W = 8;
  localparam int HDR_PAD_W = WORD_W - TS_W - ADC_W - (ADC_W + 1) - EVT_W - WCNT_W;

  // apb register port, byte address with word offsets above bit 1
  localparam int APB_DW = 32;
  localparam int CSR_AW = 4;
  localparam int APB_AW = CSR_AW + 2;

  typedef logic signed [ADC_W-1:0] sample_t;
  // one extra bit so sample minus baseline never wraps
  typedef logic signed [ADC_W:0]   thresh_t;

  // sample sits in the upper bits of its lane
  typedef struct packed {
    sample_t                   sample;
    logic [LANE_W-ADC_W-1:0]   pad;
  } lane_t;

  typedef struct packed {
    logic [HDR_PAD_W-1:0] pad;
    logic [TS_W-1:0]      ts;
    sample_t              baseline;
    thresh_t              threshold;
    logic [EVT_W-1:0]     evt_num;
    logic [WCNT_W-1:0]    word_cnt;
  } hit_header_t;

  // data words carry lanes, the first word of a packet carries the header
  typedef union packed {
    lane_t [LANES-1:0] lanes;
    hit_header_t       hdr;
  } adc_word_u;

  // register word offsets
  localparam logic [CSR_AW-1:0] CSR_CTRL      = 4'd0;
  localparam logic [CSR_AW-1:0] CSR_THRESH    = 4'd1;
  localparam logic [CSR_AW-1:0] CSR_BASE_FIX  = 4'd2;
  localparam logic [CSR_AW-1:0] CSR_BASE_MEAS = 4'd3;
  localparam logic [CSR_AW-1:0] CSR_EVT_CNT   = 4'd4;
  localparam logic [CSR_AW-1:0] CSR_TS_LO     = 4'd5;
  localparam logic [CSR_AW-1:0] CSR_TS_HI     = 4'd6;

endpackage

/* baseline_tracker.sv */
`timescale 1ns/10ps

module baseline_tracker #(
  parameter int AVG_LOG2 = 3
) (
  input  logic                              CLK,
  input  logic                              RESETN,
  input  logic [adc_trig_pkg::WORD_W-1:0]   s_data,
  input  logic                              s_valid,
  input  logic                              hit_word,
  trig_cfg_if.track                         cfg
);
  import adc_trig_pkg::*;

  // eight lanes add three bits of growth
  localparam int SUM_W = ADC_W + 3;
  localparam int ACC_W = SUM_W + AVG_LOG2;
  localparam int BLOCK = 2 ** AVG_LOG2;

  adc_word_u               in_word;
  logic signed [SUM_W-1:0] word_sum;
  logic signed [SUM_W-1:0] sum_q;
  logic signed [ACC_W-1:0] acc;
  logic signed [ACC_W-1:0] acc_next;
  logic signed [ACC_W-1:0] mean;
  logic [AVG_LOG2:0]       cnt;
  logic                    sum_valid;
  logic                    dirty;
  logic                    dirty_next;
  logic                    block_end;

  assign in_word = s_data;

  always_comb begin
    word_sum = '0;
    for (int i = 0; i < LANES; i++) begin
      word_sum = word_sum + SUM_W'(in_word.lanes[i].sample);
    end
  end

  // sum_q lines up with hit_word of the same word
  assign acc_next   = acc + ACC_W'(sum_q);
  assign dirty_next = dirty | hit_word;
  assign block_end  = sum_valid && (cnt == BLOCK - 1);
  assign mean       = acc_next >>> (AVG_LOG2 + 3);

  always_ff @(posedge CLK) begin
    sum_q <= word_sum;
  end

  always_ff @(posedge CLK or negedge RESETN) begin
    if (!RESETN) begin
      sum_valid             <= 1'b0;
      acc                   <= '0;
      cnt                   <= '0;
      dirty                 <= 1'b0;
      cfg.measured_baseline <= '0;
      cfg.measured_valid    <= 1'b0;
    end else begin
      sum_valid <= s_valid;
      if (block_end) begin
        acc   <= '0;
        cnt   <= '0;
        dirty <= 1'b0;
        // blocks that saw a hit are dropped
        if (!dirty_next) begin
          cfg.measured_baseline <= mean[ADC_W-1:0];
          cfg.measured_valid    <= 1'b1;
        end
      end else if (sum_valid) begin
        acc   <= acc_next;
        cnt   <= cnt + 1'b1;
        dirty <= dirty_next;
      end
    end
  end

endmodule

/* build.f */
adc_trig_pkg.sv
trig_cfg_if.sv
trig_event_if.sv
trig_csr.sv
hit_discriminator.sv
baseline_tracker.sv
event_framer.sv
adc_self_trigger.sv
tb_adc_self_trigger.sv

/* event_framer.sv */
`timescale 1ns/10ps

module event_framer #(
  parameter int ACQUI_LEN = 24
) (
  input  logic                              CLK,
  input  logic                              RESETN,
  trig_event_if.frame                       evt,
  output logic [adc_trig_pkg::WORD_W-1:0]   m_data,
  output logic                              m_valid,
  output logic                              m_header,
  output logic                              m_last
);
  import adc_trig_pkg::*;

  localparam int CNT_W = $clog2(ACQUI_LEN + 1);

  adc_word_u        hold_word;
  adc_word_u        out_word;
  hit_header_t      hdr;
  logic             hold_win;
  logic             hold_last;
  logic [EVT_W-1:0] evt_num;
  logic [CNT_W-1:0] word_cnt;

  // header takes the slot of the stale held word
  always_comb begin
    hdr           = '0;
    hdr.ts        = evt.ts_at_hit;
    hdr.baseline  = evt.base_at_hit;
    hdr.threshold = evt.thresh_at_hit;
    hdr.evt_num   = evt_num;
    // length of the event before this one
    hdr.word_cnt  = WCNT_W'(word_cnt);
    if (evt.hit_start) begin
      out_word.hdr = hdr;
    end else begin
      out_word.lanes = hold_word.lanes;
    end
  end

  always_ff @(posedge CLK or negedge RESETN) begin
    if (!RESETN) begin
      hold_win  <= 1'b0;
      hold_last <= 1'b0;
      m_valid   <= 1'b0;
      m_header  <= 1'b0;
      m_last    <= 1'b0;
      evt_num   <= '0;
      word_cnt  <= '0;
    end else begin
      hold_win  <= evt.data_valid & evt.window;
      hold_last <= evt.data_valid & evt.window_last;
      m_valid   <= evt.hit_start | hold_win;
      m_header  <= evt.hit_start;
      m_last    <= hold_last & ~evt.hit_start;
      if (evt.hit_start) begin
        evt_num  <= evt_num + 1'b1;
        word_cnt <= CNT_W'(1);
      end else if (evt.data_valid & evt.window) begin
        word_cnt <= word_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    hold_word <= evt.data;
    m_data    <= out_word;
  end

  a_last_valid: assert property (@(posedge CLK) disable iff (!RESETN)
    m_last |-> m_valid);

endmodule

/* hit_discriminator.sv */
`timescale 1ns/10ps

module hit_discriminator #(
  parameter int POST_LEN  = 6,
  parameter int ACQUI_LEN = 24
) (
  input  logic                              CLK,
  input  logic                              RESETN,
  input  logic [adc_trig_pkg::WORD_W-1:0]   s_data,
  input  logic                              s_valid,
  input  logic [adc_trig_pkg::TS_W-1:0]     current_time,
  input  logic                              downstream_ready,
  trig_cfg_if.disc                          cfg,
  trig_event_if.disc                        evt,
  output logic                              hit_word
);
  import adc_trig_pkg::*;

  localparam int ACQ_W  = $clog2(ACQUI_LEN + 1);
  localparam int POST_W = $clog2(POST_LEN + 2);

  adc_word_u         in_word;
  adc_word_u         clean_word;
  adc_word_u         d1;
  adc_word_u         d2;
  sample_t           eff_base;
  sample_t           base1;
  sample_t           base2;
  thresh_t           thr1;
  thresh_t           thr2;
  logic [TS_W-1:0]   ts1;
  logic [TS_W-1:0]   ts2;
  logic [LANES-1:0]  reach;
  logic              v1;
  logic              v2;
  logic              hit2;
  logic              hit3;
  logic              open_q;
  logic              start;
  logic              in_win;
  logic              win_last;
  logic [ACQ_W-1:0]  acq_cnt;
  logic [ACQ_W-1:0]  acq_next;
  logic [POST_W-1:0] post_cnt;
  logic [POST_W-1:0] post_next;
  logic              win_busy;

  assign in_word = s_data;

  // tracked baseline only once the tracker has a value
  assign eff_base = (cfg.baseline_sel && cfg.measured_valid) ?
                    cfg.measured_baseline : cfg.fixed_baseline;

  // strip pad bits and compare sample minus baseline per lane in 13 bits
  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      clean_word.lanes[i].sample = in_word.lanes[i].sample;
      clean_word.lanes[i].pad    = '0;
      reach[i] = (thresh_t'(in_word.lanes[i].sample) - thresh_t'(eff_base)) >= cfg.threshold;
    end
  end

  // window decision for the word in stage 2
  always_comb begin
    // rising edge only and never straight after a window word
    start     = v2 & hit2 & ~hit3 & ~open_q & ~evt.window & cfg.enable & downstream_ready;
    in_win    = start | (v2 & open_q);
    acq_next  = start ? ACQ_W'(1) : acq_cnt + ACQ_W'(1);
    post_next = hit2 ? '0 : post_cnt + POST_W'(1);
    win_last  = in_win & ((acq_next == ACQ_W'(ACQUI_LEN)) | (post_next == POST_W'(POST_LEN)));
  end

  // a gap in s_valid clears the hit pipeline
  always_ff @(posedge CLK or negedge RESETN) begin
    if (!RESETN) begin
      v1       <= 1'b0;
      hit_word <= 1'b0;
      v2       <= 1'b0;
      hit2     <= 1'b0;
      hit3     <= 1'b0;
    end else begin
      v1       <= s_valid;
      hit_word <= s_valid & (&reach);
      v2       <= v1;
      hit2     <= hit_word;
      hit3     <= hit2;
    end
  end

  // window flags and counters
  always_ff @(posedge CLK or negedge RESETN) begin
    if (!RESETN) begin
      evt.data_valid  <= 1'b0;
      evt.window      <= 1'b0;
      evt.window_last <= 1'b0;
      evt.hit_start   <= 1'b0;
      open_q          <= 1'b0;
      acq_cnt         <= '0;
      post_cnt        <= '0;
    end else begin
      evt.data_valid  <= v2;
      evt.window      <= in_win;
      evt.window_last <= win_last;
      evt.hit_start   <= start;
      if (in_win) begin
        acq_cnt  <= acq_next;
        post_cnt <= post_next;
      end
      if (v2) begin
        open_q <= in_win & ~win_last;
      end
    end
  end

  // data and capture path three registers deep
  always_ff @(posedge CLK) begin
    d1    <= clean_word;
    ts1   <= current_time;
    base1 <= eff_base;
    thr1  <= cfg.threshold;
    d2    <= d1;
    ts2   <= ts1;
    base2 <= base1;
    thr2  <= thr1;
    evt.data <= d2;
    if (start) begin
      evt.ts_at_hit     <= ts2;
      evt.base_at_hit   <= base2;
      evt.thresh_at_hit <= thr2;
    end
  end

  // event window as seen on the output side, from hit_start to window_last
  always_ff @(posedge CLK or negedge RESETN) begin
    if (!RESETN) begin
      win_busy <= 1'b0;
    end else if (evt.window_last) begin
      win_busy <= 1'b0;
    end else if (evt.hit_start) begin
      win_busy <= 1'b1;
    end
  end

  a_win_cap: assert property (@(posedge CLK) disable iff (!RESETN)
    evt.window [*ACQUI_LEN] |=> !evt.window);

  a_no_nested_hit: assert property (@(posedge CLK) disable iff (!RESETN)
    win_busy |-> !evt.hit_start);

endmodule

/* run_sim.sh */
#!/bin/sh
# build with verilator, run, and decide on the log contents
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_adc_self_trigger -f build.f \
  || { echo "verilator build failed"; exit 1; }
./obj_dir/Vtb_adc_self_trigger > sim.log 2>&1
cat sim.log
grep -q "^TEST RESULT: PASS$" sim.log && exit 0 || exit 1

/* tb_adc_self_trigger.sv */
`timescale 1ns/10ps

module tb_adc_self_trigger;
  import adc_trig_pkg::*;

  localparam int POST_LEN     = 6;
  localparam int ACQUI_LEN    = 24;
  // stream words and apb accesses summed over all tests
  localparam int STREAM_WORDS = 224;
  localparam int APB_ACCESSES = 20;
  localparam int CHECK_CYCLES = 240;
  localparam int TIMEOUT_NS   = (8 + STREAM_WORDS + 3 * APB_ACCESSES + CHECK_CYCLES) * 4 + 1000;

  logic              CLK;
  logic              RESETN;
  logic [WORD_W-1:0] s_data;
  logic              s_valid;
  logic [TS_W-1:0]   current_time;
  logic              downstream_ready;
  logic [APB_AW-1:0] paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [APB_DW-1:0] pwdata;
  logic [APB_DW-1:0] prdata;
  logic              pready;
  logic              pslverr;
  logic [WORD_W-1:0] m_data;
  logic              m_valid;
  logic              m_header;
  logic              m_last;

  int              seed     = 32'hf019;
  int              err_cnt  = 0;
  int              exp_evt  = 0;
  int              prev_len = 0;
  logic [TS_W-1:0] ts_now   = 48'h1234_0000_0100;
  logic [TS_W-1:0] last_ts  = '0;
  adc_word_u       sent_q[$];
  logic [TS_W-1:0] ts_q[$];
  adc_word_u       out_q[$];
  // {header, last} per output word
  logic [1:0]      flag_q[$];

  adc_self_trigger #(
    .POST_LEN  (POST_LEN),
    .ACQUI_LEN (ACQUI_LEN)
  ) i_dut (
    .CLK              (CLK),
    .RESETN           (RESETN),
    .s_data           (s_data),
    .s_valid          (s_valid),
    .current_time     (current_time),
    .downstream_ready (downstream_ready),
    .paddr            (paddr),
    .psel             (psel),
    .penable          (penable),
    .pwrite           (pwrite),
    .pwdata           (pwdata),
    .prdata           (prdata),
    .pready           (pready),
    .pslverr          (pslverr),
    .m_data           (m_data),
    .m_valid          (m_valid),
    .m_header         (m_header),
    .m_last           (m_last)
  );

  always #2 CLK = ~CLK;

  // output monitor samples on the falling edge
  always @(negedge CLK) begin
    if (RESETN && m_valid) begin
      out_q.push_back(m_data);
      flag_q.push_back({m_header, m_last});
    end
  end

  task automatic fail_stop();
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_word(input adc_word_u got, input adc_word_u exp, input string what);
    if (got !== exp) begin
      $display("Error at %0t: %s got %h, expected %h", $time, what, got, exp);
      err_cnt++;
      fail_stop();
    end
  endtask

  task automatic compare_header(input hit_header_t got, input hit_header_t exp,
                                input string what);
    if (got !== exp) begin
      $display("Error at %0t: %s got %h, expected %h", $time, what, got, exp);
      err_cnt++;
      fail_stop();
    end
  endtask

  task automatic compare_reg(input logic [APB_DW-1:0] got, input logic [APB_DW-1:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("Error at %0t: %s got %h, expected %h", $time, what, got, exp);
      err_cnt++;
      fail_stop();
    end
  endtask

  task automatic compare_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("Error at %0t: %s got %b, expected %b", $time, what, got, exp);
      err_cnt++;
      fail_stop();
    end
  endtask

  task automatic apb_write(input logic [CSR_AW-1:0] off, input logic [APB_DW-1:0] data);
    @(posedge CLK);
    paddr   <= {off, 2'b00};
    pwrite  <= 1'b1;
    pwdata  <= data;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge CLK);
    penable <= 1'b1;
    @(posedge CLK);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input logic [CSR_AW-1:0] off, output logic [APB_DW-1:0] data,
                          output logic err);
    @(posedge CLK);
    paddr   <= {off, 2'b00};
    pwrite  <= 1'b0;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge CLK);
    penable <= 1'b1;
    @(negedge CLK);
    data = prdata;
    err  = pslverr;
    compare_flag(pready, 1'b1, "pready in access phase");
    @(posedge CLK);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // lanes at level plus noise with random pad bits
  function automatic adc_word_u make_word(input int level, input int spread);
    adc_word_u w;
    int        r;
    int        noise;
    for (int i = 0; i < LANES; i++) begin
      r = $random(seed);
      noise = (r & 32'h7fff_ffff) % (spread + 1);
      w.lanes[i].sample = sample_t'(level + noise);
      w.lanes[i].pad    = r[31:28];
    end
    return w;
  endfunction

  function automatic adc_word_u clear_pads(input adc_word_u w);
    adc_word_u c;
    c = w;
    for (int i = 0; i < LANES; i++) begin
      c.lanes[i].pad = '0;
    end
    return c;
  endfunction

  task automatic send_word(input adc_word_u w);
    @(posedge CLK);
    s_data       <= w;
    s_valid      <= 1'b1;
    current_time <= ts_now;
    sent_q.push_back(w);
    ts_q.push_back(ts_now);
    ts_now = ts_now + 1;
  endtask

  task automatic send_quiet(input int n, input int level, input int spread);
    repeat (n) send_word(make_word(level, spread));
  endtask

  task automatic send_pulse(input int n, input int level, input int spread, output int first);
    first = sent_q.size();
    repeat (n) send_word(make_word(level, spread));
  endtask

  task automatic idle(input int n);
    @(posedge CLK);
    s_valid <= 1'b0;
    repeat (n) @(posedge CLK);
  endtask

  task automatic expect_silence();
    repeat (12) @(posedge CLK);
    if (out_q.size() != 0) begin
      $display("%0d output words arrived outside any expected packet", out_q.size());
      err_cnt++;
      fail_stop();
    end
  endtask

  task automatic expect_packet(input int first, input int n_data, input sample_t base,
                               input thresh_t thr);
    hit_header_t exp_hdr;
    adc_word_u   got;
    logic [1:0]  flags;
    int          waited;
    waited = 0;
    while (out_q.size() < n_data + 1 && waited < 64 + n_data) begin
      @(posedge CLK);
      waited++;
    end
    if (out_q.size() < n_data + 1) begin
      $display("packet with %0d data words did not arrive in time", n_data);
      err_cnt++;
      fail_stop();
    end
    exp_hdr           = '0;
    exp_hdr.ts        = ts_q[first];
    exp_hdr.baseline  = base;
    exp_hdr.threshold = thr;
    exp_hdr.evt_num   = EVT_W'(exp_evt);
    exp_hdr.word_cnt  = WCNT_W'(prev_len);
    got   = out_q.pop_front();
    flags = flag_q.pop_front();
    compare_flag(flags[1], 1'b1, "header flag on first word");
    compare_flag(flags[0], 1'b0, "last flag on header word");
    compare_header(got.hdr, exp_hdr, "packet header");
    for (int k = 0; k < n_data; k++) begin
      got   = out_q.pop_front();
      flags = flag_q.pop_front();
      compare_flag(flags[1], 1'b0, "header flag on data word");
      compare_flag(flags[0], k == n_data - 1, "last flag on data word");
      compare_word(got, clear_pads(sent_q[first + k]), "data word");
    end
    exp_evt++;
    prev_len = n_data;
    last_ts  = ts_q[first];
    expect_silence();
  endtask

  task automatic test_registers();
    logic [APB_DW-1:0] data;
    logic              err;
    apb_write(CSR_CTRL, 32'h1);
    apb_write(CSR_THRESH, 32'd200);
    apb_write(CSR_BASE_FIX, 32'd100);
    apb_read(CSR_CTRL, data, err);
    compare_reg(data, 32'h1, "ctrl readback");
    compare_flag(err, 1'b0, "pslverr on ctrl read");
    apb_read(CSR_THRESH, data, err);
    compare_reg(data, 32'd200, "threshold readback");
    apb_read(CSR_BASE_FIX, data, err);
    compare_reg(data, 32'd100, "fixed baseline readback");
    apb_read(4'd9, data, err);
    compare_flag(err, 1'b1, "pslverr on unmapped address");
  endtask

  task automatic test_fixed_hit();
    int first;
    send_quiet(8, 90, 15);
    send_pulse(5, 300, 15, first);
    send_quiet(POST_LEN + 8, 90, 15);
    idle(2);
    expect_packet(first, 5 + POST_LEN, sample_t'(100), thresh_t'(200));
  endtask

  task automatic test_length_cap();
    int first;
    send_quiet(8, 90, 15);
    send_pulse(30, 300, 15, first);
    send_quiet(POST_LEN + 8, 90, 15);
    idle(2);
    expect_packet(first, ACQUI_LEN, sample_t'(100), thresh_t'(200));
  endtask

  // negative threshold with one lane one count short
  task automatic test_hit_rule();
    adc_word_u w;
    int        first;
    apb_write(CSR_BASE_FIX, 32'd20);
    apb_write(CSR_THRESH, 32'h1ffb);
    send_quiet(8, -40, 15);
    w = make_word(15, 0);
    w.lanes[3].sample = sample_t'(14);
    send_word(w);
    send_quiet(POST_LEN + 8, -40, 15);
    idle(2);
    expect_silence();
    send_quiet(8, -40, 15);
    send_pulse(1, 15, 0, first);
    send_quiet(POST_LEN + 8, -40, 15);
    idle(2);
    expect_packet(first, 1 + POST_LEN, sample_t'(20), thresh_t'(-5));
  endtask

  task automatic test_tracked_baseline();
    logic [APB_DW-1:0] data;
    logic              err;
    int                first;
    // fixed baseline far above the quiet level so no hit dirties a block
    apb_write(CSR_BASE_FIX, 32'd1000);
    apb_write(CSR_THRESH, 32'd60);
    send_quiet(24, 500, 0);
    idle(4);
    apb_read(CSR_BASE_MEAS, data, err);
    compare_reg(data, 32'd500, "measured baseline");
    apb_write(CSR_CTRL, 32'h3);
    send_quiet(4, 500, 0);
    send_pulse(3, 560, 0, first);
    send_quiet(POST_LEN + 8, 500, 0);
    idle(2);
    expect_packet(first, 3 + POST_LEN, sample_t'(500), thresh_t'(60));
  endtask

  task automatic test_gating_status();
    logic [APB_DW-1:0] data;
    logic              err;
    int                first;
    apb_write(CSR_BASE_FIX, 32'd100);
    apb_write(CSR_THRESH, 32'd200);
    apb_write(CSR_CTRL, 32'h0);
    send_quiet(8, 90, 15);
    send_pulse(5, 300, 15, first);
    send_quiet(POST_LEN + 8, 90, 15);
    idle(2);
    expect_silence();
    apb_write(CSR_CTRL, 32'h1);
    downstream_ready <= 1'b0;
    send_quiet(8, 90, 15);
    send_pulse(5, 300, 15, first);
    send_quiet(POST_LEN + 8, 90, 15);
    idle(2);
    expect_silence();
    downstream_ready <= 1'b1;
    apb_read(CSR_EVT_CNT, data, err);
    compare_reg(data, exp_evt, "event count");
    apb_read(CSR_TS_LO, data, err);
    compare_reg(data, last_ts[31:0], "time stamp low");
    apb_read(CSR_TS_HI, data, err);
    compare_reg(data, {16'h0, last_ts[47:32]}, "time stamp high");
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired before the tests finished");
    fail_stop();
  end

  initial begin
    CLK              = 1'b0;
    RESETN           = 1'b0;
    s_data           = '0;
    s_valid          = 1'b0;
    current_time     = '0;
    downstream_ready = 1'b1;
    paddr            = '0;
    psel             = 1'b0;
    penable          = 1'b0;
    pwrite           = 1'b0;
    pwdata           = '0;
    repeat (8) @(posedge CLK);
    compare_flag(m_valid, 1'b0, "m_valid in reset");
    compare_flag(m_header, 1'b0, "m_header in reset");
    compare_flag(m_last, 1'b0, "m_last in reset");
    compare_flag(pslverr, 1'b0, "pslverr in reset");
    RESETN <= 1'b1;
    test_registers();
    test_fixed_hit();
    test_length_cap();
    test_hit_rule();
    test_tracked_baseline();
    test_gating_status();
    if (err_cnt == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      fail_stop();
    end
  end

endmodule

/* trig_cfg_if.sv */
`timescale 1ns/10ps

interface trig_cfg_if;
  import adc_trig_pkg::*;

  // written over apb
  logic    enable;
  logic    baseline_sel;
  thresh_t threshold;
  sample_t fixed_baseline;

  // produced by the tracker
  sample_t measured_baseline;
  logic    measured_valid;

  modport csr (
    output enable, baseline_sel, threshold, fixed_baseline,
    input  measured_baseline, measured_valid
  );

  modport disc (
    input enable, baseline_sel, threshold, fixed_baseline,
    input measured_baseline, measured_valid
  );

  modport track (
    output measured_baseline, measured_valid
  );

endinterface

/* trig_csr.sv */
`timescale 1ns/10ps

module trig_csr (
  input  logic                              CLK,
  input  logic                              RESETN,
  input  logic [adc_trig_pkg::APB_AW-1:0]   paddr,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [adc_trig_pkg::APB_DW-1:0]   pwdata,
  output logic [adc_trig_pkg::APB_DW-1:0]   prdata,
  output logic                              pready,
  output logic                              pslverr,
  trig_cfg_if.csr                           cfg,
  trig_event_if.frame                       evt
);
  import adc_trig_pkg::*;

  logic [CSR_AW-1:0] addr;
  logic              access;
  logic              wr_en;
  logic              mapped;
  logic [APB_DW-1:0] evt_cnt;
  logic [TS_W-1:0]   last_ts;

  assign addr   = paddr[APB_AW-1:2];
  assign access = psel & penable;
  assign wr_en  = access & pwrite;

  // no wait states
  assign pready = 1'b1;

  // read mux, also flags unmapped offsets
  always_comb begin
    mapped = 1'b1;
    prdata = '0;
    case (addr)
      CSR_CTRL: begin
        prdata[1:0] = {cfg.baseline_sel, cfg.enable};
      end
      CSR_THRESH: begin
        prdata[ADC_W:0] = cfg.threshold;
      end
      CSR_BASE_FIX: begin
        prdata[ADC_W-1:0] = cfg.fixed_baseline;
      end
      CSR_BASE_MEAS: begin
        prdata[ADC_W-1:0] = cfg.measured_baseline;
      end
      CSR_EVT_CNT: begin
        prdata = evt_cnt;
      end
      CSR_TS_LO: begin
        prdata = last_ts[31:0];
      end
      CSR_TS_HI: begin
        prdata[TS_W-33:0] = last_ts[TS_W-1:32];
      end
      default: begin
        mapped = 1'b0;
      end
    endcase
  end

  assign pslverr = access & ~mapped;

  // writes land at the end of the access phase
  always_ff @(posedge CLK or negedge RESETN) begin
    if (!RESETN) begin
      cfg.enable         <= 1'b0;
      cfg.baseline_sel   <= 1'b0;
      cfg.threshold      <= '0;
      cfg.fixed_baseline <= '0;
    end else if (wr_en) begin
      case (addr)
        CSR_CTRL: begin
          cfg.enable       <= pwdata[0];
          cfg.baseline_sel <= pwdata[1];
        end
        CSR_THRESH: begin
          cfg.threshold <= pwdata[ADC_W:0];
        end
        CSR_BASE_FIX: begin
          cfg.fixed_baseline <= pwdata[ADC_W-1:0];
        end
        default: begin
        end
      endcase
    end
  end

  // event status
  always_ff @(posedge CLK or negedge RESETN) begin
    if (!RESETN) begin
      evt_cnt <= '0;
      last_ts <= '0;
    end else if (evt.hit_start) begin
      evt_cnt <= evt_cnt + 1'b1;
      last_ts <= evt.ts_at_hit;
    end
  end

  a_apb_enable: assert property (@(posedge CLK) disable iff (!RESETN)
    penable |-> psel);

endmodule

/* trig_event_if.sv */
`timescale 1ns/10ps

interface trig_event_if;
  import adc_trig_pkg::*;

  // cleaned data word with its window flags
  adc_word_u       data;
  logic            data_valid;
  logic            window;
  logic            window_last;

  // first window word, capture fields hold until the next one
  logic            hit_start;
  logic [TS_W-1:0] ts_at_hit;
  sample_t         base_at_hit;
  thresh_t         thresh_at_hit;

  modport disc (
    output data, data_valid, window, window_last,
    output hit_start, ts_at_hit, base_at_hit, thresh_at_hit
  );

  modport frame (
    input data, data_valid, window, window_last,
    input hit_start, ts_at_hit, base_at_hit, thresh_at_hit
  );

endinterface
